// File: list.f
common/sirius_pkg.sv
fetch/fetch_unit.sv
logic/decoder.sv
logic/issue_ctrl.sv
logic/reg_file.sv
logic/operand_bypass.sv
logic/alu.sv
logic/sirius_core.sv
dv/tb_sirius.sv

// File: run.sh
#!/bin/sh
# Build with Verilator from list.f, run, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_sirius -f list.f -o sim_sirius \
    && ./obj_dir/sim_sirius > sim.log 2>&1
grep -q "Simulation failed" sim.log && { echo "FAIL: see sim.log"; exit 1; }
grep -q "Simulation completed successfully" sim.log || { echo "FAIL: run did not finish"; exit 1; }
echo "PASS"

// File: dv/tb_sirius.sv
`timescale 1ns/100ps

module tb_sirius;
    import sirius_pkg::*;

    localparam int PROG_LEN    = 200;
    localparam int LATE_START  = 150;
    localparam int RUN_TIMEOUT = 4000;
    localparam int REQ_TIMEOUT = 50;
    localparam logic [5:0] R_FUNCTS [11] = '{FN_SLL, FN_SRL, FN_SRA, FN_ADDU, FN_SUBU, FN_AND,
                                            FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
    localparam logic [5:0] I_OPS [7] = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
                                         OP_XORI, OP_LUI};

    logic        clk;
    logic        rst_n;
    logic        inst_ok;
    logic [1:0]  inst_valid;
    word_t       inst_data_1;
    word_t       inst_data_2;
    logic        fetch_req;
    word_t       fetch_addr;
    commit_t     commit_0;
    commit_t     commit_1;

    word_t       program_mem [PROG_LEN];
    word_t       model_regs [32];
    word_t       exp_pc [$];
    reg_addr_t   exp_dest [$];
    word_t       exp_data [$];
    logic [31:0] lcg_state;
    int          errors;
    int          committed;
    int          total_expected;
    logic        response_seen;

    sirius_core dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_ok     (inst_ok),
        .inst_valid  (inst_valid),
        .inst_data_1 (inst_data_1),
        .inst_data_2 (inst_data_2),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .commit_0    (commit_0),
        .commit_1    (commit_1)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int unsigned next_rand(int unsigned range);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 8) % range;
    endfunction

    function automatic word_t r_format(logic [5:0] funct, reg_addr_t rd, reg_addr_t rs,
                                       reg_addr_t rt, logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, funct};
    endfunction

    function automatic word_t i_format(logic [5:0] op, reg_addr_t rt, reg_addr_t rs,
                                       logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t random_instr();
        int unsigned kind;
        int unsigned k;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        kind = next_rand(40);
        rs   = 5'(next_rand(8));
        rt   = 5'(next_rand(8));
        rd   = 5'(next_rand(8));
        sh   = 5'(next_rand(32));
        imm  = 16'(next_rand(65536));
        k    = kind % 18;
        // Undefined forms with an unknown major opcode or funct
        if (kind == 38) begin
            return {6'h3f, rs, rt, imm};
        end else if (kind == 39) begin
            return r_format(6'h3e, rd, rs, rt, 5'd0);
        end else if (k < 3) begin
            return r_format(R_FUNCTS[k], rd, 5'd0, rt, sh);
        end else if (k < 11) begin
            return r_format(R_FUNCTS[k], rd, rs, rt, 5'd0);
        end
        return i_format(I_OPS[k - 11], rt, rs, imm);
    endfunction

    // Returns {known, dest, data} by MIPS semantics
    function automatic logic [37:0] ref_exec(word_t instr, word_t a, word_t b);
        logic [4:0] sh;
        logic [4:0] dest;
        logic       known;
        word_t      simm;
        word_t      zimm;
        word_t      res;
        sh    = instr[10:6];
        simm  = {{16{instr[15]}}, instr[15:0]};
        zimm  = {16'h0000, instr[15:0]};
        known = 1'b1;
        res   = '0;
        dest  = instr[20:16];
        if (instr[31:26] == 6'h00) begin
            dest = instr[15:11];
            case (instr[5:0])
                6'h00: res = b << sh;
                6'h02: res = b >> sh;
                6'h03: res = $signed(b) >>> sh;
                6'h21: res = a + b;
                6'h23: res = a - b;
                6'h24: res = a & b;
                6'h25: res = a | b;
                6'h26: res = a ^ b;
                6'h27: res = ~(a | b);
                6'h2a: res = {31'd0, $signed(a) < $signed(b)};
                6'h2b: res = {31'd0, a < b};
                default: known = 1'b0;
            endcase
        end else begin
            case (instr[31:26])
                6'h09: res = a + simm;
                6'h0a: res = {31'd0, $signed(a) < $signed(simm)};
                6'h0b: res = {31'd0, a < simm};
                6'h0c: res = a & zimm;
                6'h0d: res = a | zimm;
                6'h0e: res = a ^ zimm;
                6'h0f: res = {instr[15:0], 16'h0000};
                default: known = 1'b0;
            endcase
        end
        if (dest == 5'd0) begin
            res = '0;
        end
        return {known, dest, res};
    endfunction

    task automatic build_program();
        // Dependent chain through the EX and WB bypass paths
        program_mem[0]  = i_format(OP_ORI, 5'd1, 5'd0, 16'h1234);
        program_mem[1]  = r_format(FN_ADDU, 5'd2, 5'd1, 5'd1, 5'd0);
        program_mem[2]  = i_format(OP_ORI, 5'd3, 5'd2, 16'h00f0);
        program_mem[3]  = r_format(FN_ADDU, 5'd4, 5'd3, 5'd2, 5'd0);
        program_mem[4]  = r_format(FN_SUBU, 5'd5, 5'd4, 5'd1, 5'd0);
        program_mem[5]  = i_format(OP_ORI, 5'd6, 5'd5, 16'h8001);
        program_mem[6]  = r_format(FN_ADDU, 5'd7, 5'd6, 5'd6, 5'd0);
        program_mem[7]  = i_format(OP_LUI, 5'd1, 5'd0, 16'h8000);
        program_mem[8]  = r_format(FN_SRA, 5'd2, 5'd0, 5'd1, 5'd4);
        program_mem[9]  = i_format(OP_SLTIU, 5'd3, 5'd0, 16'hffff);
        program_mem[10] = r_format(FN_ADDU, 5'd0, 5'd7, 5'd7, 5'd0);
        program_mem[11] = r_format(FN_ADDU, 5'd4, 5'd0, 5'd3, 5'd0);
        for (int i = 12; i < PROG_LEN; i++) begin
            program_mem[i] = random_instr();
        end
    endtask

    task automatic build_expected();
        logic [37:0] r;
        word_t       instr;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            instr = program_mem[i];
            r = ref_exec(instr, model_regs[instr[25:21]], model_regs[instr[20:16]]);
            if (r[37]) begin
                exp_pc.push_back(word_t'(i * 4));
                exp_dest.push_back(r[36:32]);
                exp_data.push_back(r[31:0]);
                model_regs[r[36:32]] = r[31:0];
            end
        end
        total_expected = exp_pc.size();
    endtask

    task automatic report_mismatch(string name, word_t expected, word_t actual);
        errors++;
        $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    endtask

    task automatic check_commit(commit_t c, int lane);
        word_t     e_pc;
        reg_addr_t e_dest;
        word_t     e_data;
        if (c.valid) begin
            assert (response_seen) else begin
                errors++;
                $display("Lane %0d committed before any fetch response was accepted", lane);
            end
            assert (exp_pc.size() > 0) else begin
                errors++;
                $display("Lane %0d committed pc %h with nothing left to commit", lane, c.pc);
            end
            if (exp_pc.size() > 0) begin
                e_pc   = exp_pc.pop_front();
                e_dest = exp_dest.pop_front();
                e_data = exp_data.pop_front();
                committed++;
                assert (c.pc == e_pc)
                    else report_mismatch($sformatf("lane %0d commit order pc", lane), e_pc, c.pc);
                assert (c.dest == e_dest)
                    else report_mismatch($sformatf("lane %0d dest at pc %h", lane, e_pc),
                                         word_t'(e_dest), word_t'(c.dest));
                assert (c.data == e_data)
                    else report_mismatch($sformatf("lane %0d data at pc %h", lane, e_pc),
                                         e_data, c.data);
            end
        end
    endtask

    initial begin : compare_commits
        for (int cyc = 0; cyc < RUN_TIMEOUT + 100; cyc++) begin
            @(negedge clk);
            if (rst_n === 1'b1) begin
                // Lane 0 is the older one
                check_commit(commit_0, 0);
                check_commit(commit_1, 1);
            end
        end
    end

    initial begin : instruction_source
        int   idx;
        int   delay;
        int   timer;
        logic two;
        idx   = 0;
        timer = 0;
        while (rst_n !== 1'b1 && timer < 20) begin
            @(negedge clk);
            timer++;
        end
        while (idx < PROG_LEN) begin
            timer = 0;
            @(negedge clk);
            while (!fetch_req && timer < REQ_TIMEOUT) begin
                @(negedge clk);
                timer++;
            end
            if (!fetch_req) begin
                errors++;
                $display("fetch_req stayed low for %0d cycles at %h", REQ_TIMEOUT, fetch_addr);
                break;
            end
            idx = int'(fetch_addr >> 2);
            if (idx < PROG_LEN) begin
                // Program tail answers late and one word at a time
                delay = (idx >= LATE_START) ? 2 : int'(next_rand(3));
                two   = (idx < LATE_START) && (idx + 1 < PROG_LEN) && (next_rand(2) == 1);
                @(posedge clk);
                repeat (delay) @(posedge clk);
                #1;
                inst_ok     = 1'b1;
                inst_valid  = two ? 2'b11 : 2'b01;
                inst_data_1 = program_mem[idx];
                inst_data_2 = two ? program_mem[idx + 1] : '0;
                @(posedge clk);
                response_seen = 1'b1;
                #1;
                inst_ok    = 1'b0;
                inst_valid = 2'b00;
            end
        end
    end

    initial begin : main
        int cycles;
        rst_n          = 1'b0;
        inst_ok        = 1'b0;
        inst_valid     = 2'b00;
        inst_data_1    = '0;
        inst_data_2    = '0;
        errors         = 0;
        committed      = 0;
        response_seen  = 1'b0;
        lcg_state      = 32'd77;
        build_program();
        build_expected();
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        assert (fetch_addr == 32'h0000_0000)
            else report_mismatch("fetch_addr after reset", 32'h0000_0000, fetch_addr);
        assert (!fetch_req && !commit_0.valid && !commit_1.valid) else begin
            errors++;
            $display("fetch_req or a commit valid was high right after reset");
        end
        cycles = 0;
        while (committed < total_expected && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (committed < total_expected) begin
            errors++;
            $display("Timeout: %0d of %0d instructions committed", committed, total_expected);
        end
        // Catch stray commits after the last expected one
        repeat (20) @(negedge clk);
        $display("Commits checked: %0d of %0d, errors: %0d", committed, total_expected, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: logic/sirius_core.sv
`timescale 1ns/100ps

module sirius_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inst_ok,
    input  logic [1:0]          inst_valid,
    input  sirius_pkg::word_t   inst_data_1,
    input  sirius_pkg::word_t   inst_data_2,
    output logic                fetch_req,
    output sirius_pkg::word_t   fetch_addr,
    output sirius_pkg::commit_t commit_0,
    output sirius_pkg::commit_t commit_1
);
    import sirius_pkg::*;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        alu_op_e    alu_op;
        reg_addr_t  dest;
        logic       wen;
        word_t      src_a;
        word_t      src_b;
        logic [4:0] shamt;
    } id_ex_t;

    fetch_entry_t    head [2];
    logic [1:0]      count_ok;
    logic [1:0]      pop_count;
    logic            issue_slave;
    logic [1:0]      lane_issue;
    decoded_t        dec [2];
    reg_addr_t [3:0] src_addr;
    word_t [3:0]     file_data;
    word_t [3:0]     src_value;
    id_ex_t          id_ex [2];
    id_ex_t          id_ex_next [2];
    word_t           alu_result [2];
    stage_t          ex_stage [2];
    stage_t          ex_wb [2];

    fetch_unit u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_ok     (inst_ok),
        .inst_valid  (inst_valid),
        .inst_data_1 (inst_data_1),
        .inst_data_2 (inst_data_2),
        .pop_count   (pop_count),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .head0       (head[0]),
        .head1       (head[1]),
        .count_ok    (count_ok)
    );

    issue_ctrl u_issue (
        .count_ok    (count_ok),
        .master      (dec[0]),
        .slave       (dec[1]),
        .pop_count   (pop_count),
        .issue_slave (issue_slave)
    );

    assign lane_issue = {issue_slave, pop_count != 2'd0};

    // Read ports in order master rs, master rt, slave rs, slave rt
    assign src_addr = {dec[1].rt, dec[1].rs, dec[0].rt, dec[0].rs};

    reg_file u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr (src_addr),
        .rdata (file_data),
        .wr_0  (ex_wb[0]),
        .wr_1  (ex_wb[1])
    );

    for (genvar i = 0; i < 4; i++) begin : g_bypass
        operand_bypass u_bypass (
            .addr      (src_addr[i]),
            .file_data (file_data[i]),
            .ex_1      (ex_stage[1]),
            .ex_0      (ex_stage[0]),
            .wb_1      (ex_wb[1]),
            .wb_0      (ex_wb[0]),
            .value     (src_value[i])
        );
    end

    for (genvar l = 0; l < 2; l++) begin : g_lane
        decoder u_dec (
            .instr   (head[l].instr),
            .present (count_ok > 2'(l)),
            .decoded (dec[l])
        );

        alu u_alu (
            .op     (id_ex[l].alu_op),
            .src_a  (id_ex[l].src_a),
            .src_b  (id_ex[l].src_b),
            .shamt  (id_ex[l].shamt),
            .result (alu_result[l])
        );
    end

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            // Bubbles and a held slave load an invalid record
            id_ex_next[l].valid  = lane_issue[l] && dec[l].valid;
            id_ex_next[l].pc     = head[l].pc;
            id_ex_next[l].alu_op = dec[l].alu_op;
            id_ex_next[l].dest   = dec[l].dest;
            id_ex_next[l].wen    = dec[l].wen;
            id_ex_next[l].src_a  = src_value[2*l];
            id_ex_next[l].src_b  = dec[l].use_imm ? dec[l].imm : src_value[2*l+1];
            id_ex_next[l].shamt  = dec[l].shamt;
        end
    end

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            ex_stage[l].valid  = id_ex[l].valid;
            ex_stage[l].pc     = id_ex[l].pc;
            ex_stage[l].dest   = id_ex[l].dest;
            ex_stage[l].wen    = id_ex[l].wen;
            ex_stage[l].result = (id_ex[l].dest == '0) ? '0 : alu_result[l];
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < 2; l++) begin
            id_ex[l] <= id_ex_next[l];
            ex_wb[l] <= ex_stage[l];
        end
        if (!rst_n) begin
            for (int l = 0; l < 2; l++) begin
                id_ex[l].valid <= 1'b0;
                ex_wb[l].valid <= 1'b0;
            end
        end
    end

    assign commit_0 = '{valid: ex_wb[0].valid, pc: ex_wb[0].pc,
                        dest: ex_wb[0].dest, data: ex_wb[0].result};
    assign commit_1 = '{valid: ex_wb[1].valid, pc: ex_wb[1].pc,
                        dest: ex_wb[1].dest, data: ex_wb[1].result};

    // A full pair always holds two neighbouring queue entries
    a_pair_order: assert property (@(posedge clk) disable iff (!rst_n)
        commit_0.valid && commit_1.valid |-> commit_1.pc == commit_0.pc + 32'd4);

endmodule

// File: logic/alu.sv
`timescale 1ns/100ps

module alu (
    input  sirius_pkg::alu_op_e op,
    input  sirius_pkg::word_t   src_a,
    input  sirius_pkg::word_t   src_b,
    input  logic [4:0]          shamt,
    output sirius_pkg::word_t   result
);
    import sirius_pkg::*;

    logic signed_lt;
    logic unsigned_lt;

    assign signed_lt   = $signed(src_a) < $signed(src_b);
    assign unsigned_lt = src_a < src_b;

    always_comb begin
        case (op)
            ALU_ADD:  result = src_a + src_b;
            ALU_SUB:  result = src_a - src_b;
            ALU_AND:  result = src_a & src_b;
            ALU_OR:   result = src_a | src_b;
            ALU_XOR:  result = src_a ^ src_b;
            ALU_NOR:  result = ~(src_a | src_b);
            ALU_SLT:  result = {31'd0, signed_lt};
            ALU_SLTU: result = {31'd0, unsigned_lt};
            // Shifts act on rt
            ALU_SLL:  result = src_b << shamt;
            ALU_SRL:  result = src_b >> shamt;
            ALU_SRA:  result = $unsigned($signed(src_b) >>> shamt);
            ALU_LUI:  result = {src_b[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

endmodule

// File: logic/operand_bypass.sv
`timescale 1ns/100ps

module operand_bypass (
    input  sirius_pkg::reg_addr_t addr,
    input  sirius_pkg::word_t     file_data,
    input  sirius_pkg::stage_t    ex_1,
    input  sirius_pkg::stage_t    ex_0,
    input  sirius_pkg::stage_t    wb_1,
    input  sirius_pkg::stage_t    wb_0,
    output sirius_pkg::word_t     value
);
    import sirius_pkg::*;

    function automatic logic hit(stage_t s, reg_addr_t a);
        return s.valid && s.wen && (s.dest == a) && (a != '0);
    endfunction

    // Youngest producer first
    always_comb begin
        if (hit(ex_1, addr)) begin
            value = ex_1.result;
        end else if (hit(ex_0, addr)) begin
            value = ex_0.result;
        end else if (hit(wb_1, addr)) begin
            value = wb_1.result;
        end else if (hit(wb_0, addr)) begin
            value = wb_0.result;
        end else begin
            value = file_data;
        end
    end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                        clk,
    input  logic                        rst_n,
    input  sirius_pkg::reg_addr_t [3:0] raddr,
    output sirius_pkg::word_t [3:0]     rdata,
    input  sirius_pkg::stage_t          wr_0,
    input  sirius_pkg::stage_t          wr_1
);
    import sirius_pkg::*;

    word_t regs [32];

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rdata[i] = (raddr[i] == '0) ? '0 : regs[raddr[i]];
        end
    end

    // Lane 1 is younger, so its write lands last
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_0.valid && wr_0.wen) begin
                regs[wr_0.dest] <= wr_0.result;
            end
            if (wr_1.valid && wr_1.wen) begin
                regs[wr_1.dest] <= wr_1.result;
            end
        end
    end

    a_write_addr_known: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_0.valid && $isunknown(wr_0.dest)) && !(wr_1.valid && $isunknown(wr_1.dest)));

endmodule

// File: logic/issue_ctrl.sv
`timescale 1ns/100ps

module issue_ctrl (
    input  logic [1:0]           count_ok,
    input  sirius_pkg::decoded_t master,
    input  sirius_pkg::decoded_t slave,
    output logic [1:0]           pop_count,
    output logic                 issue_slave
);

    logic master_writes;
    logic rs_hazard;
    logic rt_hazard;

    // r0 never creates a dependency
    assign master_writes = master.valid && master.wen && (master.dest != 5'd0);

    assign rs_hazard = master_writes && (slave.rs == master.dest);

    // Immediate forms use rt as destination, not as a source
    assign rt_hazard = master_writes && !slave.use_imm && (slave.rt == master.dest);

    assign issue_slave = (count_ok == 2'd2) && !rs_hazard && !rt_hazard;

    always_comb begin
        if (count_ok == 2'd0) begin
            pop_count = 2'd0;
        end else if (issue_slave) begin
            pop_count = 2'd2;
        end else begin
            pop_count = 2'd1;
        end
    end

endmodule

// File: logic/decoder.sv
`timescale 1ns/100ps

module decoder (
    input  sirius_pkg::word_t    instr,
    input  logic                 present,
    output sirius_pkg::decoded_t decoded
);
    import sirius_pkg::*;

    opcode_e     opcode;
    funct_e      funct;
    logic [15:0] imm16;
    logic        known;
    logic        r_type;
    logic        sign_ext;
    alu_op_e     op;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);
    assign imm16  = instr[15:0];

    always_comb begin
        known    = 1'b1;
        r_type   = 1'b0;
        sign_ext = 1'b0;
        op       = ALU_ADD;
        case (opcode)
            OP_SPECIAL: begin
                r_type = 1'b1;
                case (funct)
                    FN_ADDU: op = ALU_ADD;
                    FN_SUBU: op = ALU_SUB;
                    FN_AND:  op = ALU_AND;
                    FN_OR:   op = ALU_OR;
                    FN_XOR:  op = ALU_XOR;
                    FN_NOR:  op = ALU_NOR;
                    FN_SLT:  op = ALU_SLT;
                    FN_SLTU: op = ALU_SLTU;
                    FN_SLL:  op = ALU_SLL;
                    FN_SRL:  op = ALU_SRL;
                    FN_SRA:  op = ALU_SRA;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                op       = ALU_ADD;
                sign_ext = 1'b1;
            end
            // SLTIU compares unsigned but still sign-extends
            OP_SLTI: begin
                op       = ALU_SLT;
                sign_ext = 1'b1;
            end
            OP_SLTIU: begin
                op       = ALU_SLTU;
                sign_ext = 1'b1;
            end
            OP_ANDI: op = ALU_AND;
            OP_ORI:  op = ALU_OR;
            OP_XORI: op = ALU_XOR;
            OP_LUI:  op = ALU_LUI;
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        decoded.valid   = present && known;
        decoded.alu_op  = op;
        decoded.rs      = instr[25:21];
        decoded.rt      = instr[20:16];
        decoded.dest    = r_type ? instr[15:11] : instr[20:16];
        decoded.wen     = present && known;
        decoded.use_imm = !r_type;
        decoded.imm     = sign_ext ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};
        decoded.shamt   = instr[10:6];
    end

endmodule

// File: fetch/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     inst_ok,
    input  logic [1:0]               inst_valid,
    input  sirius_pkg::word_t        inst_data_1,
    input  sirius_pkg::word_t        inst_data_2,
    input  logic [1:0]               pop_count,
    output logic                     fetch_req,
    output sirius_pkg::word_t        fetch_addr,
    output sirius_pkg::fetch_entry_t head0,
    output sirius_pkg::fetch_entry_t head1,
    output logic [1:0]               count_ok
);
    import sirius_pkg::*;

    fetch_entry_t           queue [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr_1;
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] wr_ptr_1;
    logic [QUEUE_PTR_W:0]   count;
    logic [QUEUE_PTR_W:0]   count_next;
    logic                   wr_first;
    logic                   wr_second;
    logic [1:0]             wr_count;
    word_t                  pc;

    // Second word only counts together with the first
    assign wr_first  = inst_ok && inst_valid[0];
    assign wr_second = inst_ok && inst_valid[0] && inst_valid[1];
    assign wr_count  = {1'b0, wr_first} + {1'b0, wr_second};

    assign rd_ptr_1 = rd_ptr + QUEUE_PTR_W'(1);
    assign wr_ptr_1 = wr_ptr + QUEUE_PTR_W'(1);

    assign count_next = count + (QUEUE_PTR_W+1)'(wr_count)
                      - (QUEUE_PTR_W+1)'(pop_count);

    always_ff @(posedge clk) begin
        if (wr_first) begin
            queue[wr_ptr] <= '{instr: inst_data_1, pc: pc};
        end
        if (wr_second) begin
            queue[wr_ptr_1] <= '{instr: inst_data_2, pc: pc + 32'd4};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr    <= '0;
            wr_ptr    <= '0;
            count     <= '0;
            pc        <= RESET_PC;
            fetch_req <= 1'b0;
        end else begin
            rd_ptr <= rd_ptr + QUEUE_PTR_W'(pop_count);
            wr_ptr <= wr_ptr + QUEUE_PTR_W'(wr_count);
            count  <= count_next;
            pc     <= pc + word_t'({wr_count, 2'b00});
            // Keep room for one response still in flight
            fetch_req <= count_next <= (QUEUE_PTR_W+1)'(QUEUE_DEPTH - 4);
        end
    end

    assign fetch_addr = pc;
    assign head0      = queue[rd_ptr];
    assign head1      = queue[rd_ptr_1];
    assign count_ok   = (count >= (QUEUE_PTR_W+1)'(2)) ? 2'd2 : count[1:0];

    a_room_for_write: assert property (@(posedge clk) disable iff (!rst_n)
        inst_ok |-> count <= (QUEUE_PTR_W+1)'(QUEUE_DEPTH - 2));

    // Issue never takes entries that are not there
    a_pop_bound: assert property (@(posedge clk) disable iff (!rst_n)
        pop_count <= count_ok);

endmodule

// File: common/sirius_pkg.sv
package sirius_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int    QUEUE_DEPTH = 8;
    localparam int    QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam word_t RESET_PC    = 32'h0000_0000;

    // Major opcodes kept from the full core
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        word_t instr;
        word_t pc;
    } fetch_entry_t;

    typedef struct packed {
        logic       valid;
        alu_op_e    alu_op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  dest;
        logic       wen;
        logic       use_imm;
        word_t      imm;
        logic [4:0] shamt;
    } decoded_t;

    // One lane in EX or WB
    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t dest;
        logic      wen;
        word_t     result;
    } stage_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t dest;
        word_t     data;
    } commit_t;

endpackage
